// ==== Bender.yml ====
package:
  name: c3sram_macro

sources:
  - logic/wb_pkg.sv
  - logic/c3sram_pkg.sv
  - logic/c3sram_wb_slave.sv
  - logic/row_access_ctrl.sv
  - logic/c3sram_array.sv
  - logic/c3sram_macro.sv
  - target: test
    files:
      - sim/c3sram_checker.sv
      - sim/tb_c3sram_macro.sv

// ==== c3sram_macro.f ====
logic/wb_pkg.sv
logic/c3sram_pkg.sv
logic/c3sram_wb_slave.sv
logic/row_access_ctrl.sv
logic/c3sram_array.sv
logic/c3sram_macro.sv
sim/c3sram_checker.sv
sim/tb_c3sram_macro.sv

// ==== logic/c3sram_array.sv ====
`default_nettype none

module c3sram_array (
    input  logic                  clk,
    input  logic                  nrst,
    input  c3sram_pkg::wordline_t wl_i,
    input  logic                  w2b_i,
    input  logic                  nprecharge_i,
    input  logic                  saen_i,
    input  c3sram_pkg::col_word_t wr_data_i,
    output c3sram_pkg::col_word_t rd_data_o
);

    import c3sram_pkg::*;

    col_word_t cells_q [NUM_ROWS];
    col_word_t bitline;
    col_word_t sense_q;
    logic      wr_drive;
    logic      sense_fire;

    // Write drivers are on the bitlines only while precharge is released
    assign wr_drive = w2b_i && nprecharge_i;

    always_ff @(posedge clk) begin
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (wl_i[r] && wr_drive) begin
                cells_q[r] <= wr_data_i;
            end
        end
    end

    // Bitlines see the OR of every row whose wordline is up
    always_comb begin
        bitline = '0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (wl_i[r]) begin
                bitline = bitline | cells_q[r];
            end
        end
    end

    assign sense_fire = saen_i && nprecharge_i && $onehot(wl_i);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sense_q <= '0;
        end else if (sense_fire) begin
            sense_q <= bitline;
        end
    end

    assign rd_data_o = sense_q;

    // Two rows on one bitline would short the cells
    assert property (@(posedge clk) disable iff (!nrst) $onehot0(wl_i));

endmodule

`default_nettype wire

// ==== logic/c3sram_macro.sv ====
`default_nettype none

module c3sram_macro (
    input  logic            clk,
    input  logic            nrst,
    input  logic            cyc_i,
    input  logic            stb_i,
    input  logic            we_i,
    input  wb_pkg::wb_adr_t adr_i,
    input  wb_pkg::wb_dat_t dat_i,
    output logic            ack_o,
    output wb_pkg::wb_dat_t dat_o
);

    import c3sram_pkg::*;

    // Slave to sequencer
    logic      cmd_write;
    logic      cmd_read;
    row_addr_t cmd_row;
    col_word_t cmd_data;
    logic      seq_ready;
    logic      seq_done;

    // Sequencer to array
    col_word_t arr_wr_data;
    wordline_t arr_wl;
    logic      arr_w2b;
    logic      arr_saen;
    logic      arr_nprecharge;
    col_word_t sense_data;

    c3sram_wb_slave slave0 (
        .clk          (clk),
        .nrst         (nrst),
        .cyc_i        (cyc_i),
        .stb_i        (stb_i),
        .we_i         (we_i),
        .adr_i        (adr_i),
        .dat_i        (dat_i),
        .ack_o        (ack_o),
        .dat_o        (dat_o),
        .cmd_write_o  (cmd_write),
        .cmd_read_o   (cmd_read),
        .cmd_row_o    (cmd_row),
        .cmd_data_o   (cmd_data),
        .seq_ready_i  (seq_ready),
        .seq_done_i   (seq_done),
        .sense_data_i (sense_data)
    );

    row_access_ctrl ctrl0 (
        .clk          (clk),
        .nrst         (nrst),
        .write_i      (cmd_write),
        .read_i       (cmd_read),
        .addr_i       (cmd_row),
        .wr_data_i    (cmd_data),
        .done_o       (seq_done),
        .ready_o      (seq_ready),
        .wr_data_o    (arr_wr_data),
        .wl_o         (arr_wl),
        .w2b_o        (arr_w2b),
        .saen_o       (arr_saen),
        .nprecharge_o (arr_nprecharge)
    );

    c3sram_array array0 (
        .clk          (clk),
        .nrst         (nrst),
        .wl_i         (arr_wl),
        .w2b_i        (arr_w2b),
        .nprecharge_i (arr_nprecharge),
        .saen_i       (arr_saen),
        .wr_data_i    (arr_wr_data),
        .rd_data_o    (sense_data)
    );

endmodule

`default_nettype wire

// ==== logic/c3sram_pkg.sv ====
`default_nettype none

package c3sram_pkg;

    // Array geometry
    localparam int NUM_ROWS = 128;
    localparam int NUM_COLS = 32;

    // Row index into the bitcell array
    typedef logic [$clog2(NUM_ROWS)-1:0] row_addr_t;

    // One row of bitcells, also the width of the write drivers and sense latch
    typedef logic [NUM_COLS-1:0] col_word_t;

    // One wire per row, at most one of them high
    typedef logic [NUM_ROWS-1:0] wordline_t;

endpackage

`default_nettype wire

// ==== logic/c3sram_wb_slave.sv ====
`default_nettype none

module c3sram_wb_slave (
    input  logic                  clk,
    input  logic                  nrst,
    // Wishbone classic slave port
    input  logic                  cyc_i,
    input  logic                  stb_i,
    input  logic                  we_i,
    input  wb_pkg::wb_adr_t       adr_i,
    input  wb_pkg::wb_dat_t       dat_i,
    output logic                  ack_o,
    output wb_pkg::wb_dat_t       dat_o,
    // Commands to the row sequencer
    output logic                  cmd_write_o,
    output logic                  cmd_read_o,
    output c3sram_pkg::row_addr_t cmd_row_o,
    output c3sram_pkg::col_word_t cmd_data_o,
    input  logic                  seq_ready_i,
    input  logic                  seq_done_i,
    // Sense latch of the array
    input  c3sram_pkg::col_word_t sense_data_i
);

    import wb_pkg::*;
    import c3sram_pkg::*;

    localparam int ROW_ADR_MSB = ROW_ADR_LSB + $bits(row_addr_t) - 1;

    logic busy_q;
    logic rd_pending_q;
    logic ack_q;
    logic rd_ack_q;
    logic start;
    logic in_range;

    // Anything above the row field must be zero
    assign in_range = ~|adr_i[WB_ADR_W-1:ROW_ADR_MSB+1];

    // New strobe, only while idle and not in the ack cycle
    assign start = cyc_i && stb_i && !busy_q && !ack_q;

    assign cmd_row_o   = adr_i[ROW_ADR_MSB:ROW_ADR_LSB];
    assign cmd_data_o  = dat_i;
    assign cmd_write_o = start && in_range && seq_ready_i && we_i;
    assign cmd_read_o  = start && in_range && seq_ready_i && !we_i;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            busy_q       <= 1'b0;
            rd_pending_q <= 1'b0;
            ack_q        <= 1'b0;
            rd_ack_q     <= 1'b0;
        end else begin
            ack_q    <= 1'b0;
            rd_ack_q <= 1'b0;
            if (cmd_write_o || cmd_read_o) begin
                busy_q       <= 1'b1;
                rd_pending_q <= cmd_read_o;
            end else if (busy_q && seq_done_i) begin
                // Sequencer finished, acknowledge next cycle
                busy_q   <= 1'b0;
                ack_q    <= 1'b1;
                rd_ack_q <= rd_pending_q;
            end else if (start && !in_range) begin
                // Out of range, ack right away with no access
                ack_q <= 1'b1;
            end
        end
    end

    assign ack_o = ack_q;

    // Sense latch holds the row from its capture until the next read
    assign dat_o = rd_ack_q ? sense_data_i : '0;

    // One transfer in flight, no second command before the first is acked
    assert property (@(posedge clk) disable iff (!nrst)
        (cmd_write_o || cmd_read_o) |=> !(cmd_write_o || cmd_read_o) until_with ack_o);

endmodule

`default_nettype wire

// ==== logic/row_access_ctrl.sv ====
`default_nettype none

module row_access_ctrl (
    input  logic                  clk,
    input  logic                  nrst,
    // Command side, one pulse per access while ready
    input  logic                  write_i,
    input  logic                  read_i,
    input  c3sram_pkg::row_addr_t addr_i,
    input  c3sram_pkg::col_word_t wr_data_i,
    output logic                  done_o,
    output logic                  ready_o,
    // Array control waveforms
    output c3sram_pkg::col_word_t wr_data_o,
    output c3sram_pkg::wordline_t wl_o,
    output logic                  w2b_o,
    output logic                  saen_o,
    output logic                  nprecharge_o
);

    import c3sram_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,
        ST_READ
    } seq_state_t;

    // Waveforms indexed by the phase counter, phase 3 first
    localparam logic [3:0] W2B_WAVE_WR  = 4'b1111;
    localparam logic [3:0] NPRE_WAVE_WR = 4'b1111;
    localparam logic [3:0] WL_WAVE_WR   = 4'b0110;
    localparam logic [3:0] SAEN_WAVE_RD = 4'b0010;
    localparam logic [3:0] NPRE_WAVE_RD = 4'b1110;
    localparam logic [3:0] WL_WAVE_RD   = 4'b0110;

    seq_state_t state_q;
    seq_state_t state_d;
    logic [1:0] phase_q;
    row_addr_t  row_q;
    col_word_t  data_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (write_i) begin
                    state_d = ST_WRITE;
                end else if (read_i) begin
                    state_d = ST_READ;
                end
            end
            ST_WRITE, ST_READ: begin
                if (phase_q == 2'd0) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q <= ST_IDLE;
            phase_q <= 2'd3;
        end else begin
            state_q <= state_d;
            // Counter parks at 3 in idle and runs down during an access
            if (state_q == ST_IDLE) begin
                phase_q <= 2'd3;
            end else begin
                phase_q <= phase_q - 2'd1;
            end
        end
    end

    // Latch the target row, and the write word on writes
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && (write_i || read_i)) begin
            row_q <= addr_i;
            if (write_i) begin
                data_q <= wr_data_i;
            end
        end
    end

    always_comb begin
        wl_o         = '0;
        w2b_o        = 1'b0;
        saen_o       = 1'b0;
        nprecharge_o = 1'b0;
        case (state_q)
            ST_WRITE: begin
                wl_o[row_q]  = WL_WAVE_WR[phase_q];
                w2b_o        = W2B_WAVE_WR[phase_q];
                nprecharge_o = NPRE_WAVE_WR[phase_q];
            end
            ST_READ: begin
                wl_o[row_q]  = WL_WAVE_RD[phase_q];
                saen_o       = SAEN_WAVE_RD[phase_q];
                nprecharge_o = NPRE_WAVE_RD[phase_q];
            end
            default: ;
        endcase
    end

    assign wr_data_o = data_q;
    assign ready_o   = (state_q == ST_IDLE);

    // Reads finish one phase early, the latch is valid after phase 1
    assign done_o = ((state_q == ST_WRITE) && (phase_q == 2'd0)) ||
                    ((state_q == ST_READ) && (phase_q == 2'd1));

    assert property (@(posedge clk) disable iff (!nrst) !(write_i && read_i));
    assert property (@(posedge clk) disable iff (!nrst) $onehot0(wl_o));
    assert property (@(posedge clk) disable iff (!nrst) !(saen_o && w2b_o));

endmodule

`default_nettype wire

// ==== logic/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

    // Wishbone widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;

    // Byte address and data word on the bus
    typedef logic [WB_ADR_W-1:0] wb_adr_t;
    typedef logic [WB_DAT_W-1:0] wb_dat_t;

    // Row field starts above the byte offset, one row per 32-bit word
    localparam int ROW_ADR_LSB = 2;

endpackage

`default_nettype wire

// ==== sim/c3sram_checker.sv ====
`default_nettype none

module c3sram_checker (
    input  logic            clk,
    input  logic            nrst,
    // Bus signals as seen at the DUT
    input  logic            cyc_i,
    input  logic            stb_i,
    input  logic            we_i,
    input  wb_pkg::wb_adr_t adr_i,
    input  wb_pkg::wb_dat_t dat_i,
    input  logic            ack_i,
    input  wb_pkg::wb_dat_t rdata_i,
    // Running totals for the closing report
    output int              checks_o,
    output int              errors_o,
    output int              acks_o
);

    import wb_pkg::*;

    localparam int WRITE_LATENCY = 5;
    localparam int READ_LATENCY  = 4;
    localparam int OOR_LATENCY   = 1;

    // Reference memory is unknown until a row is written
    wb_dat_t ref_mem [128];
    string   test_name = "none";
    logic    busy = 1'b0;
    int      cycles = 0;
    logic    xfer_we;
    wb_adr_t xfer_adr;
    wb_dat_t xfer_dat;
    int      n_checks = 0;
    int      n_errors = 0;
    int      n_acks = 0;

    assign checks_o = n_checks;
    assign errors_o = n_errors;
    assign acks_o   = n_acks;

    // Rows live in bits 8..2 and anything set above bit 8 is out of range
    function automatic logic in_range(input wb_adr_t adr);
        return adr[31:9] == '0;
    endfunction

    // Word a read should return under the bus rules
    function automatic wb_dat_t ref_read(input wb_adr_t adr);
        if (!in_range(adr)) begin
            return '0;
        end
        return ref_mem[adr[8:2]];
    endfunction

    task automatic set_test(input string name);
        test_name = name;
    endtask

    task automatic check_value(input string what, input wb_dat_t exp, input wb_dat_t act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_latency();
        int exp;
        if (!in_range(xfer_adr)) begin
            exp = OOR_LATENCY;
        end else if (xfer_we) begin
            exp = WRITE_LATENCY;
        end else begin
            exp = READ_LATENCY;
        end
        n_checks++;
        if (cycles != exp) begin
            n_errors++;
            $display("FAILED %s latency at %h: expected %0d, actual %0d",
                     test_name, xfer_adr, exp, cycles);
        end
    endtask

    task automatic finish_transfer();
        if (!in_range(xfer_adr)) begin
            check_value("out of range dat_o", ref_read(xfer_adr), rdata_i);
        end else if (xfer_we) begin
            ref_mem[xfer_adr[8:2]] = xfer_dat;
        end else begin
            check_value($sformatf("read row %0d", xfer_adr[8:2]), ref_read(xfer_adr), rdata_i);
        end
    endtask

    // Cycle 0 ends at the first edge with a strobe and ack is due in cycle k
    always @(posedge clk) begin
        if (!nrst) begin
            busy = 1'b0;
            if (ack_i !== 1'b0) begin
                n_errors++;
                $display("ack_o is not low during reset at time %0t", $time);
            end
        end else if (busy) begin
            cycles++;
            if (ack_i === 1'b1) begin
                busy = 1'b0;
                n_acks++;
                check_latency();
                finish_transfer();
            end
        end else begin
            if (ack_i === 1'b1) begin
                n_errors++;
                $display("ack_o went high with no transfer in flight at time %0t", $time);
            end
            if (cyc_i && stb_i) begin
                busy     = 1'b1;
                cycles   = 0;
                xfer_we  = we_i;
                xfer_adr = adr_i;
                xfer_dat = dat_i;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_c3sram_macro.sv ====
`default_nettype none

module tb_c3sram_macro;

    import wb_pkg::*;
    import c3sram_pkg::*;

    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 8;
    localparam int OVERWRITE_ROUNDS = 8;
    localparam int OOR_ROUNDS       = 4;
    localparam int BURST_LEN        = 16;
    localparam int NUM_XFERS        = 2 + 2 * NUM_ROWS + 4 * OVERWRITE_ROUNDS +
                                      3 * OOR_ROUNDS + BURST_LEN;
    // Longest transfer plus gap stays below 8 cycles
    localparam int WATCHDOG_CYCLES  = NUM_XFERS * 8 + RESET_CYCLES + 100;

    logic    clk;
    logic    nrst;
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    wb_dat_t wdat;
    logic    ack;
    wb_dat_t rdat;
    integer  seed = 32'h26974f5c;
    int      n_xfers = 0;
    int      checks;
    int      errors;
    int      acks;

    c3sram_macro dut0 (
        .clk   (clk),
        .nrst  (nrst),
        .cyc_i (cyc),
        .stb_i (stb),
        .we_i  (we),
        .adr_i (adr),
        .dat_i (wdat),
        .ack_o (ack),
        .dat_o (rdat)
    );

    c3sram_checker chk0 (
        .clk      (clk),
        .nrst     (nrst),
        .cyc_i    (cyc),
        .stb_i    (stb),
        .we_i     (we),
        .adr_i    (adr),
        .dat_i    (wdat),
        .ack_i    (ack),
        .rdata_i  (rdat),
        .checks_o (checks),
        .errors_o (errors),
        .acks_o   (acks)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Called at a falling edge and returns at the falling edge of the ack cycle
    task automatic bus_xfer(input logic write, input wb_adr_t address, input wb_dat_t data);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = write;
        adr  = address;
        wdat = data;
        do begin
            @(negedge clk);
        end while (ack !== 1'b1);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        n_xfers++;
    endtask

    task automatic write_row(input row_addr_t row, input wb_dat_t data);
        bus_xfer(1'b1, wb_adr_t'(row) << 2, data);
    endtask

    task automatic read_row(input row_addr_t row);
        bus_xfer(1'b0, wb_adr_t'(row) << 2, '0);
    endtask

    task automatic idle_cycle();
        @(negedge clk);
    endtask

    initial begin
        row_addr_t row;
        wb_adr_t   oor_adr;
        int        i;
        int        total_errors;
        nrst = 1'b1;
        cyc  = 1'b0;
        stb  = 1'b0;
        we   = 1'b0;
        adr  = '0;
        wdat = '0;
        // Give the asynchronous reset a real falling edge before the first clock
        #1;
        nrst = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        nrst = 1'b1;
        idle_cycle();

        // First access after reset goes to row 0
        chk0.set_test("reset");
        write_row('0, $random(seed));
        idle_cycle();
        read_row('0);
        idle_cycle();

        chk0.set_test("write_readback");
        for (i = 0; i < NUM_ROWS; i++) begin
            write_row(row_addr_t'(i), $random(seed));
            idle_cycle();
        end
        for (i = 0; i < NUM_ROWS; i++) begin
            read_row(row_addr_t'(i));
            idle_cycle();
        end

        // Neighbours wrap at the array edges
        chk0.set_test("overwrite");
        for (i = 0; i < OVERWRITE_ROUNDS; i++) begin
            row = $random(seed);
            write_row(row, $random(seed));
            idle_cycle();
            read_row(row);
            idle_cycle();
            read_row(row - 1'b1);
            idle_cycle();
            read_row(row + 1'b1);
            idle_cycle();
        end

        chk0.set_test("out_of_range");
        for (i = 0; i < OOR_ROUNDS; i++) begin
            oor_adr = $random(seed);
            oor_adr[1:0] = 2'b00;
            oor_adr[9 + 7 * i] = 1'b1;
            bus_xfer(1'b1, oor_adr, $random(seed));
            idle_cycle();
            // Row that the dropped bits would alias to
            bus_xfer(1'b0, oor_adr & 32'h0000_01fc, '0);
            idle_cycle();
            bus_xfer(1'b0, oor_adr, '0);
            idle_cycle();
        end

        // Next strobe goes up right after each ack
        chk0.set_test("back_to_back");
        for (i = 0; i < BURST_LEN; i++) begin
            row = $random(seed);
            if (i % 2 == 0) begin
                write_row(row, $random(seed));
            end else begin
                read_row(row);
            end
        end

        repeat (4) idle_cycle();
        total_errors = errors;
        if (acks != n_xfers) begin
            total_errors++;
            $display("Saw %0d acks for %0d bus transfers", acks, n_xfers);
        end
        $display("Transfers: %0d, acks: %0d, checks: %0d, errors: %0d",
                 n_xfers, acks, checks, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: bus transfers did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
